//--- common/eeprom_consts.svh
`ifndef EEPROM_CONSTS_SVH
`define EEPROM_CONSTS_SVH

// Array geometry
`define EEPROM_DEPTH 2048
`define EEPROM_ADDR_W 11

// Block select field of the control byte, bits 3:1
`define BLOCK_SEL_W 3

// Upper nibble of every valid control byte
`define DEV_CODE 4'b1010

// Flops per line synchronizer
`define SYNC_STAGES 2

`endif

//--- common/eeprom_pkg.sv
package eeprom_pkg;

    // One bus event per scl cycle at most
    typedef enum logic [2:0] {
        ev_none     = 3'd0,
        ev_start    = 3'd1,
        ev_stop     = 3'd2,
        ev_clk_rise = 3'd3,
        ev_clk_fall = 3'd4
    } bus_event_t;

    typedef enum logic [3:0] {
        st_idle,
        st_get_ctrl,
        st_ack_ctrl,
        st_get_addr,
        st_ack_addr,
        st_get_data,
        st_ack_data,
        st_send_data,
        st_wait_mack,
        st_ignore
    } ctrl_state_t;

    // Low bit of the control byte
    typedef enum logic {
        op_write = 1'b0,
        op_read  = 1'b1
    } op_t;

endpackage

//--- verilog/bus_sampler.sv
`include "eeprom_consts.svh"

module bus_sampler
    import eeprom_pkg::*;
(
    input  logic       scl,
    input  logic       rst_n,
    input  logic       ser_clk,
    input  logic       ser_data_in,
    output bus_event_t bus_event,
    output logic       data_bit
);

    logic [`SYNC_STAGES-1:0] clk_sync;
    logic [`SYNC_STAGES-1:0] data_sync;
    logic                    clk_s;
    logic                    data_s;
    logic                    clk_prev;
    logic                    data_prev;
    bus_event_t              event_next;

    assign clk_s  = clk_sync[`SYNC_STAGES-1];
    assign data_s = data_sync[`SYNC_STAGES-1];

    // Idle bus is high on both lines
    always_ff @(posedge scl)
    begin
        if (!rst_n)
        begin
            clk_sync  <= '1;
            data_sync <= '1;
            clk_prev  <= 1'b1;
            data_prev <= 1'b1;
        end
        else
        begin
            clk_sync  <= {clk_sync[`SYNC_STAGES-2:0], ser_clk};
            data_sync <= {data_sync[`SYNC_STAGES-2:0], ser_data_in};
            clk_prev  <= clk_s;
            data_prev <= data_s;
        end
    end

    // Data edge with clock held high is a start or stop
    always_comb
    begin
        event_next = ev_none;
        if (clk_s && clk_prev && (data_s != data_prev))
            event_next = data_s ? ev_stop : ev_start;
        else if (clk_s && !clk_prev)
            event_next = ev_clk_rise;
        else if (!clk_s && clk_prev)
            event_next = ev_clk_fall;
    end

    always_ff @(posedge scl)
    begin
        if (!rst_n)
        begin
            bus_event <= ev_none;
            data_bit  <= 1'b1;
        end
        else
        begin
            bus_event <= event_next;
            data_bit  <= data_s;
        end
    end

    // Start and stop only come while the synchronized clock holds steady
    a_start_stop_steady_clk: assert property (
        @(posedge scl) disable iff (!rst_n)
        (bus_event == ev_start || bus_event == ev_stop) |-> $stable(clk_s)
    ) else $error("start or stop seen in a cycle where the bus clock changed");

endmodule

//--- serial_ctrl/serial_ctrl.sv
`include "eeprom_consts.svh"

module serial_ctrl
    import eeprom_pkg::*;
(
    input  logic                      scl,
    input  logic                      rst_n,
    input  bus_event_t                bus_event,
    input  logic                      data_bit,
    output logic                      mem_we,
    output logic                      mem_re,
    output logic [`EEPROM_ADDR_W-1:0] mem_addr,
    output logic [7:0]                data_byte,
    output logic                      ack_req,
    output logic                      load_tx
);

    ctrl_state_t                   state;
    logic [2:0]                    bit_cnt;
    logic [7:0]                    shift_reg;
    logic [`BLOCK_SEL_W-1:0]       block_sel;
    logic [7:0]                    addr_byte;
    logic                          addr_set;
    op_t                           op;
    logic [7:0]                    byte_in;
    logic                          byte_done;
    logic                          code_ok;

    // Byte including the bit sampled in this cycle
    assign byte_in   = {shift_reg[6:0], data_bit};
    assign byte_done = (bus_event == ev_clk_rise) && (bit_cnt == 3'd7);
    assign code_ok   = (byte_in[7:4] == `DEV_CODE);

    always_ff @(posedge scl)
    begin
        if (!rst_n)
        begin
            state     <= st_idle;
            bit_cnt   <= '0;
            block_sel <= '0;
            addr_byte <= '0;
            addr_set  <= 1'b0;
            op        <= op_write;
            mem_we    <= 1'b0;
            mem_re    <= 1'b0;
            ack_req   <= 1'b0;
            load_tx   <= 1'b0;
        end
        else
        begin
            mem_we  <= 1'b0;
            mem_re  <= 1'b0;
            ack_req <= 1'b0;
            load_tx <= mem_re;

            if (bus_event == ev_start)
            begin
                // Repeated start keeps the address of this transaction
                state   <= st_get_ctrl;
                bit_cnt <= '0;
            end
            else if (bus_event == ev_stop)
            begin
                state    <= st_idle;
                addr_set <= 1'b0;
            end
            else if (bus_event == ev_clk_rise)
            begin
                case (state)
                    st_get_ctrl:
                    begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (byte_done)
                        begin
                            if (code_ok && (byte_in[0] == op_write || addr_set))
                            begin
                                op        <= op_t'(byte_in[0]);
                                block_sel <= byte_in[3:1];
                                ack_req   <= 1'b1;
                                state     <= st_ack_ctrl;
                            end
                            else
                                state <= st_ignore;
                        end
                    end
                    st_ack_ctrl:
                    begin
                        bit_cnt <= '0;
                        if (op == op_read)
                        begin
                            mem_re   <= 1'b1;
                            mem_addr <= {block_sel, addr_byte};
                            state    <= st_send_data;
                        end
                        else
                            state <= st_get_addr;
                    end
                    st_get_addr:
                    begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (byte_done)
                        begin
                            addr_byte <= byte_in;
                            addr_set  <= 1'b1;
                            ack_req   <= 1'b1;
                            state     <= st_ack_addr;
                        end
                    end
                    st_ack_addr:
                    begin
                        bit_cnt <= '0;
                        state   <= st_get_data;
                    end
                    st_get_data:
                    begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (byte_done)
                        begin
                            mem_we    <= 1'b1;
                            mem_addr  <= {block_sel, addr_byte};
                            data_byte <= byte_in;
                            ack_req   <= 1'b1;
                            state     <= st_ack_data;
                        end
                    end
                    st_ack_data:
                        state <= st_idle;
                    st_send_data:
                    begin
                        // Master samples our bits on these edges
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= st_wait_mack;
                    end
                    st_wait_mack:
                    begin
                        // No sequential read, so an ack from the master is ignored
                        state <= data_bit ? st_idle : st_ignore;
                    end
                    default:
                        state <= state;
                endcase
            end
        end
    end

    always_ff @(posedge scl)
    begin
        shift_reg <= (bus_event == ev_clk_rise) ? byte_in : shift_reg;
    end

    a_we_re_exclusive: assert property (
        @(posedge scl) disable iff (!rst_n)
        !(mem_we && mem_re)
    ) else $error("array write and read requested together");

    a_ack_req_pulse: assert property (
        @(posedge scl) disable iff (!rst_n)
        ack_req |=> !ack_req
    ) else $error("ack_req held for more than one cycle");

endmodule

//--- verilog/eeprom_array.sv
`include "eeprom_consts.svh"

module eeprom_array
(
    input  logic                      scl,
    input  logic                      mem_we,
    input  logic                      mem_re,
    input  logic [`EEPROM_ADDR_W-1:0] mem_addr,
    input  logic [7:0]                data_byte,
    output logic [7:0]                mem_rdata
);

    // Contents undefined until written
    logic [7:0] mem [`EEPROM_DEPTH];

    always_ff @(posedge scl)
    begin
        if (mem_we)
            mem[mem_addr] <= data_byte;
    end

    // Registered read with data one cycle after mem_re
    always_ff @(posedge scl)
    begin
        if (mem_re)
            mem_rdata <= mem[mem_addr];
    end

    a_addr_known: assert property (
        @(posedge scl)
        (mem_we || mem_re) |-> !$isunknown(mem_addr)
    ) else $error("array accessed with an unknown address");

endmodule

//--- verilog/sda_driver.sv
module sda_driver
    import eeprom_pkg::*;
(
    input  logic       scl,
    input  logic       rst_n,
    input  bus_event_t bus_event,
    input  logic       ack_req,
    input  logic       load_tx,
    input  logic [7:0] mem_rdata,
    output logic       ser_data_oe
);

    logic       ack_pend;
    logic       tx_pend;
    logic [7:0] tx_buf;
    logic [2:0] tx_cnt;

    always_ff @(posedge scl)
    begin
        if (!rst_n)
        begin
            ack_pend    <= 1'b0;
            tx_pend     <= 1'b0;
            tx_cnt      <= '0;
            ser_data_oe <= 1'b0;
        end
        else if (bus_event == ev_start || bus_event == ev_stop)
        begin
            // Release the line immediately
            ack_pend    <= 1'b0;
            tx_pend     <= 1'b0;
            tx_cnt      <= '0;
            ser_data_oe <= 1'b0;
        end
        else if (bus_event == ev_clk_fall)
        begin
            if (tx_pend)
            begin
                ser_data_oe <= ~tx_buf[7];
                tx_cnt      <= 3'd7;
                tx_pend     <= 1'b0;
            end
            else if (tx_cnt != 3'd0)
            begin
                ser_data_oe <= ~tx_buf[7];
                tx_cnt      <= tx_cnt - 3'd1;
            end
            else if (ack_pend)
            begin
                ser_data_oe <= 1'b1;
                ack_pend    <= 1'b0;
            end
            else
                ser_data_oe <= 1'b0;
        end
        else
        begin
            if (ack_req)
                ack_pend <= 1'b1;
            if (load_tx)
                tx_pend <= 1'b1;
        end
    end

    // Byte shifts out MSB first, one bit per falling bus clock
    always_ff @(posedge scl)
    begin
        if (load_tx)
            tx_buf <= mem_rdata;
        else if (bus_event == ev_clk_fall && (tx_pend || tx_cnt != 3'd0))
            tx_buf <= {tx_buf[6:0], 1'b0};
    end

    a_oe_changes_on_event: assert property (
        @(posedge scl) disable iff (!rst_n)
        $changed(ser_data_oe)
            |-> ($past(bus_event) inside {ev_clk_fall, ev_start, ev_stop})
    ) else $error("data line enable changed outside a falling clock, start or stop");

endmodule

//--- verilog/eeprom_top.sv
`include "eeprom_consts.svh"

module eeprom_top
    import eeprom_pkg::*;
(
    input  logic scl,
    input  logic rst_n,
    input  logic ser_clk,
    input  logic ser_data_in,
    output logic ser_data_oe
);

    bus_event_t                bus_event;
    logic                      data_bit;
    logic                      mem_we;
    logic                      mem_re;
    logic [`EEPROM_ADDR_W-1:0] mem_addr;
    logic [7:0]                data_byte;
    logic [7:0]                mem_rdata;
    logic                      ack_req;
    logic                      load_tx;

    bus_sampler i_bus_sampler (
        .scl         (scl),
        .rst_n       (rst_n),
        .ser_clk     (ser_clk),
        .ser_data_in (ser_data_in),
        .bus_event   (bus_event),
        .data_bit    (data_bit)
    );

    serial_ctrl i_serial_ctrl (
        .scl       (scl),
        .rst_n     (rst_n),
        .bus_event (bus_event),
        .data_bit  (data_bit),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_addr  (mem_addr),
        .data_byte (data_byte),
        .ack_req   (ack_req),
        .load_tx   (load_tx)
    );

    eeprom_array i_eeprom_array (
        .scl       (scl),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_addr  (mem_addr),
        .data_byte (data_byte),
        .mem_rdata (mem_rdata)
    );

    // Read data goes straight from the array into the output shifter
    sda_driver i_sda_driver (
        .scl         (scl),
        .rst_n       (rst_n),
        .bus_event   (bus_event),
        .ack_req     (ack_req),
        .load_tx     (load_tx),
        .mem_rdata   (mem_rdata),
        .ser_data_oe (ser_data_oe)
    );

endmodule

//--- bench/eeprom_tb.sv
`include "eeprom_consts.svh"

module eeprom_tb
    import eeprom_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // scl cycles per bus clock phase, and one bus bit in ns
    localparam int PHASE     = 6;
    localparam int BIT_NS    = 2 * PHASE * 10;
    localparam int FULL_BYTE = 8;

    typedef struct {
        string                   name;
        op_t                     op;
        logic [3:0]              dev_code;
        logic [`BLOCK_SEL_W-1:0] block_sel;
        logic [7:0]              addr;
        logic [7:0]              data;
        int                      abort_after_bits;
        logic                    set_addr;
        logic                    exp_ack;
    } op_entry_t;

    logic       scl;
    logic       rst_n;
    logic       ser_clk;
    logic       master_sda;
    logic       ser_data_in;
    logic       ser_data_oe;
    logic       ops_ready;
    integer     seed;
    op_entry_t  ops[$];
    logic [7:0] ref_mem[int];

    // Open-drain line, low if either side pulls it
    assign ser_data_in = master_sda & ~ser_data_oe;

    eeprom_top i_dut (
        .scl         (scl),
        .rst_n       (rst_n),
        .ser_clk     (ser_clk),
        .ser_data_in (ser_data_in),
        .ser_data_oe (ser_data_oe)
    );

    initial
    begin
        scl = 1'b0;
        forever #5 scl = ~scl;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_ack(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("mismatch %s: expected %0b, actual %0b", name, exp, act));
    endtask

    task automatic check_data(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
            abort_run($sformatf("mismatch %s: expected %02h, actual %02h", name, exp, act));
    endtask

    task automatic wait_scl(input int n);
        repeat (n) @(negedge scl);
    endtask

    // Data is already set; low phase, then high phase with a sample in the middle
    task automatic clock_bit(output logic line);
        wait_scl(PHASE);
        ser_clk = 1'b1;
        wait_scl(PHASE / 2);
        line = ser_data_in;
        wait_scl(PHASE - PHASE / 2);
        ser_clk = 1'b0;
    endtask

    task automatic bus_start();
        master_sda = 1'b1;
        wait_scl(PHASE);
        ser_clk = 1'b1;
        wait_scl(PHASE);
        master_sda = 1'b0;
        wait_scl(PHASE);
        ser_clk = 1'b0;
    endtask

    task automatic bus_stop();
        master_sda = 1'b0;
        wait_scl(PHASE);
        ser_clk = 1'b1;
        wait_scl(PHASE);
        master_sda = 1'b1;
        wait_scl(PHASE);
    endtask

    task automatic send_bits(input logic [7:0] value, input int nbits);
        logic unused_line;
        for (int i = 0; i < nbits; i++)
        begin
            master_sda = value[7 - i];
            clock_bit(unused_line);
        end
    endtask

    task automatic send_byte(input logic [7:0] value, output logic acked);
        logic line;
        send_bits(value, 8);
        master_sda = 1'b1;
        clock_bit(line);
        acked = ~line;
    endtask

    // Ends with a not-acknowledge, no sequential read
    task automatic recv_byte(output logic [7:0] value);
        logic line;
        master_sda = 1'b1;
        value = '0;
        for (int i = 0; i < 8; i++)
        begin
            clock_bit(line);
            value = {value[6:0], line};
        end
        clock_bit(line);
    endtask

    function automatic void add_op(input string name, input op_t op, input logic [3:0] dev,
                                   input logic [2:0] blk, input logic [7:0] addr,
                                   input int abort_bits, input logic set_addr,
                                   input logic exp_ack);
        op_entry_t e;
        e.name             = name;
        e.op               = op;
        e.dev_code         = dev;
        e.block_sel        = blk;
        e.addr             = addr;
        e.data             = 8'($random(seed));
        e.abort_after_bits = abort_bits;
        e.set_addr         = set_addr;
        e.exp_ack          = exp_ack;
        ops.push_back(e);
    endfunction

    // Abort counts stay below 7, the stop's own rising clock adds a bit
    function automatic void build_ops();
        add_op("wr_b0_a35", op_write, `DEV_CODE, 3'd0, 8'h35, FULL_BYTE, 1'b1, 1'b1);
        add_op("rd_b0_a35", op_read, `DEV_CODE, 3'd0, 8'h35, FULL_BYTE, 1'b1, 1'b1);
        add_op("wr_b5_a35", op_write, `DEV_CODE, 3'd5, 8'h35, FULL_BYTE, 1'b1, 1'b1);
        add_op("rd_b5_a35", op_read, `DEV_CODE, 3'd5, 8'h35, FULL_BYTE, 1'b1, 1'b1);
        add_op("rd_b0_a35_kept", op_read, `DEV_CODE, 3'd0, 8'h35, FULL_BYTE, 1'b1, 1'b1);
        add_op("wr_b7_aff", op_write, `DEV_CODE, 3'd7, 8'hff, FULL_BYTE, 1'b1, 1'b1);
        add_op("rd_b7_aff", op_read, `DEV_CODE, 3'd7, 8'hff, FULL_BYTE, 1'b1, 1'b1);
        add_op("wr_b3_a00", op_write, `DEV_CODE, 3'd3, 8'h00, FULL_BYTE, 1'b1, 1'b1);
        add_op("bad_code_b5_a35", op_write, 4'b1011, 3'd5, 8'h35, FULL_BYTE, 1'b1, 1'b0);
        add_op("rd_b5_a35_after_bad", op_read, `DEV_CODE, 3'd5, 8'h35, FULL_BYTE, 1'b1, 1'b1);
        add_op("abort_b0_a35", op_write, `DEV_CODE, 3'd0, 8'h35, 4, 1'b1, 1'b1);
        add_op("rd_b0_a35_after_abort", op_read, `DEV_CODE, 3'd0, 8'h35, FULL_BYTE, 1'b1, 1'b1);
        add_op("rd_no_addr_b3", op_read, `DEV_CODE, 3'd3, 8'h00, FULL_BYTE, 1'b0, 1'b0);
        add_op("rd_b3_a00", op_read, `DEV_CODE, 3'd3, 8'h00, FULL_BYTE, 1'b1, 1'b1);
    endfunction

    task automatic run_write(input op_entry_t e);
        logic acked;
        bus_start();
        send_byte({e.dev_code, e.block_sel, op_write}, acked);
        check_ack({e.name, " ctrl ack"}, e.exp_ack, acked);
        send_byte(e.addr, acked);
        check_ack({e.name, " addr ack"}, e.exp_ack, acked);
        if (e.abort_after_bits < FULL_BYTE)
        begin
            send_bits(e.data, e.abort_after_bits);
            bus_stop();
        end
        else
        begin
            send_byte(e.data, acked);
            check_ack({e.name, " data ack"}, e.exp_ack, acked);
            bus_stop();
            if (e.exp_ack)
                ref_mem[int'({e.block_sel, e.addr})] = e.data;
        end
    endtask

    task automatic run_read(input op_entry_t e);
        logic       acked;
        logic [7:0] rdata;
        int         key;
        key = int'({e.block_sel, e.addr});
        bus_start();
        if (e.set_addr)
        begin
            // Dummy write sets the address, then a repeated start
            send_byte({e.dev_code, e.block_sel, op_write}, acked);
            check_ack({e.name, " ctrl ack"}, e.exp_ack, acked);
            send_byte(e.addr, acked);
            check_ack({e.name, " addr ack"}, e.exp_ack, acked);
            bus_start();
        end
        send_byte({e.dev_code, e.block_sel, op_read}, acked);
        check_ack({e.name, " read ctrl ack"}, e.exp_ack, acked);
        if (acked)
        begin
            recv_byte(rdata);
            if (!ref_mem.exists(key))
                abort_run({e.name, ": read of an address that was never written"});
            check_data({e.name, " read data"}, ref_mem[key], rdata);
        end
        bus_stop();
    endtask

    initial
    begin
        longint limit_ns;
        wait (ops_ready);
        limit_ns = longint'(ops.size() + 1) * 40 * BIT_NS + 1000;
        #(limit_ns);
        abort_run("watchdog: the bus transactions did not finish in time");
    end

    initial
    begin
        rst_n      = 1'b0;
        ser_clk    = 1'b1;
        master_sda = 1'b1;
        ops_ready  = 1'b0;
        seed       = 32'ha095;
        build_ops();
        ops_ready = 1'b1;
        wait_scl(3);
        rst_n = 1'b1;
        wait_scl(2);
        check_ack("reset_oe", 1'b0, ser_data_oe);
        foreach (ops[i])
        begin
            if (ops[i].op == op_write)
                run_write(ops[i]);
            else
                run_read(ops[i]);
            wait_scl(2 * PHASE);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- eeprom_serial.f
+incdir+common
common/eeprom_pkg.sv
verilog/bus_sampler.sv
serial_ctrl/serial_ctrl.sv
verilog/eeprom_array.sv
verilog/sda_driver.sv
verilog/eeprom_top.sv
bench/eeprom_tb.sv

//--- Makefile
TOP := eeprom_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f eeprom_serial.f -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
